// File: include/layer6_consts.svh
`ifndef LAYER6_CONSTS_SVH
`define LAYER6_CONSTS_SVH

//==========================================================================
// Layer-6 activation buffer geometry
//==========================================================================

// Buffer depth in words
`define LAYER6_DEPTH   64
`define LAYER6_ADDR_W  6
`define LAYER6_WORD_W  128

// One activation and how many share a word
`define ACT_W          8
`define ACT_LANES      16

`endif

// File: verilog/layer6_pkg.sv
`include "layer6_consts.svh"

package layer6_pkg;

  // Lane number inside one buffer word
  typedef logic [$clog2(`ACT_LANES)-1:0] lane_idx_t;

  //==========================================================================
  // Buffer word
  //==========================================================================

  // Raw view for the macro, lane view for packing and unpacking
  // Lane 0 sits in the low byte
  typedef union packed {
    logic [`LAYER6_WORD_W-1:0]                raw;
    logic signed [`ACT_LANES-1:0][`ACT_W-1:0] lanes;
  } feature_word_u;

endpackage

// File: verilog/layer6_sram.sv
`timescale 1ns/10ps
`include "layer6_consts.svh"

module layer6_sram
  import layer6_pkg::*;
(
  input  logic                      ck,
  input  logic                      wean,
  input  logic [`LAYER6_ADDR_W-1:0] a,
  input  feature_word_u             dia,
  input  logic                      oeb,
  input  logic [`LAYER6_ADDR_W-1:0] b,
  output feature_word_u             dob
);

  //==========================================================================
  // Storage array
  //==========================================================================

  feature_word_u mem [`LAYER6_DEPTH];

  // Port A, write only, active-low enable
  always_ff @(posedge ck) begin
    if (!wean) begin
      mem[a] <= dia;
    end
  end

  // Port B, read only
  // Output register holds its value while oeb is low
  always_ff @(posedge ck) begin
    if (oeb) begin
      dob <= mem[b];
    end
  end

endmodule

// File: verilog/layer6_wrapper.sv
`timescale 1ns/10ps
`include "layer6_consts.svh"

module layer6_wrapper
  import layer6_pkg::*;
(
  input  logic                      ck,
  input  logic                      wr_en,
  input  logic [`LAYER6_ADDR_W-1:0] wr_addr,
  input  feature_word_u             wr_word,
  input  logic                      rd_en,
  input  logic [`LAYER6_ADDR_W-1:0] rd_addr,
  output feature_word_u             rd_word
);

  logic [`LAYER6_ADDR_W-1:0] mem_a;
  logic                      mem_wean;

  //==========================================================================
  // Same-word conflict steering
  //==========================================================================

  // A read on port B wins the word, the write moves to its neighbour
  always_comb begin
    mem_a = wr_addr;
    if (rd_en && (wr_addr == rd_addr)) begin
      mem_a = {wr_addr[`LAYER6_ADDR_W-1:1], ~wr_addr[0]};
    end
  end

  // Macro write enable is active low
  assign mem_wean = ~wr_en;

  layer6_sram u_sram (
    .ck   (ck),
    .wean (mem_wean),
    .a    (mem_a),
    .dia  (wr_word),
    .oeb  (rd_en),
    .b    (rd_addr),
    .dob  (rd_word)
  );

endmodule

// File: verilog/layer6_writer.sv
`timescale 1ns/10ps
`include "layer6_consts.svh"

module layer6_writer
  import layer6_pkg::*;
(
  input  logic                      ck,
  input  logic                      reset,
  input  logic                      layer_start,
  input  logic                      act_valid,
  input  logic [`ACT_W-1:0]         act_data,
  output logic                      wr_en,
  output logic [`LAYER6_ADDR_W-1:0] wr_addr,
  output feature_word_u             wr_word,
  output logic                      layer_done
);

  // First 15 lanes of the word being packed
  logic [`ACT_LANES-2:0][`ACT_W-1:0] stage;
  lane_idx_t                         lane_cnt;
  logic                              accept;
  logic                              last_lane;

  // A layer restart drops any byte presented with it
  assign accept    = act_valid & ~layer_start;
  assign last_lane = (lane_cnt == lane_idx_t'(`ACT_LANES - 1));
  assign wr_en     = accept & last_lane;

  //==========================================================================
  // Word assembly
  //==========================================================================

  // Top lane comes straight from the input on the writing edge
  always_comb begin
    for (int i = 0; i < `ACT_LANES - 1; i++) begin
      wr_word.lanes[i] = stage[i];
    end
    wr_word.lanes[`ACT_LANES-1] = act_data;
  end

  always_ff @(posedge ck) begin
    if (accept && !last_lane) begin
      stage[lane_cnt] <= act_data;
    end
  end

  //==========================================================================
  // Lane count, word address and completion
  //==========================================================================

  always_ff @(posedge ck) begin
    if (reset || layer_start) begin
      lane_cnt <= '0;
      wr_addr  <= '0;
    end else if (accept) begin
      lane_cnt <= lane_cnt + 1'b1;
      // Address wraps to 0 after word 63
      if (last_lane) begin
        wr_addr <= wr_addr + 1'b1;
      end
    end
  end

  always_ff @(posedge ck) begin
    if (reset) begin
      layer_done <= 1'b0;
    end else begin
      layer_done <= wr_en && (wr_addr == `LAYER6_ADDR_W'(`LAYER6_DEPTH - 1));
    end
  end

endmodule

// File: verilog/layer6_reader.sv
`timescale 1ns/10ps
`include "layer6_consts.svh"

module layer6_reader
  import layer6_pkg::*;
(
  input  logic                      ck,
  input  logic                      reset,
  input  logic                      rd_req,
  input  logic [`LAYER6_ADDR_W-1:0] rd_addr,
  input  lane_idx_t                 rd_lane,
  output logic                      mem_rd_en,
  output logic [`LAYER6_ADDR_W-1:0] mem_rd_addr,
  input  feature_word_u             rd_word,
  output logic                      rd_valid,
  output logic [`ACT_W-1:0]         rd_data
);

  lane_idx_t lane_q;

  // Port B registers the word on the request edge
  assign mem_rd_en   = rd_req;
  assign mem_rd_addr = rd_addr;

  always_ff @(posedge ck) begin
    if (reset) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= rd_req;
    end
  end

  // Lane follows the word through the macro's output register
  always_ff @(posedge ck) begin
    if (rd_req) begin
      lane_q <= rd_lane;
    end
  end

  assign rd_data = rd_word.lanes[lane_q];

endmodule

// File: verilog/layer6_buffer_top.sv
`timescale 1ns/10ps
`include "layer6_consts.svh"

module layer6_buffer_top
  import layer6_pkg::*;
(
  input  logic                      ck,
  input  logic                      reset,
  input  logic                      act_valid,
  input  logic [`ACT_W-1:0]         act_data,
  input  logic                      layer_start,
  input  logic                      rd_req,
  input  logic [`LAYER6_ADDR_W-1:0] rd_addr,
  input  lane_idx_t                 rd_lane,
  output logic                      rd_valid,
  output logic [`ACT_W-1:0]         rd_data,
  output logic                      layer_done
);

  // Port A, write side
  logic                      wr_en;
  logic [`LAYER6_ADDR_W-1:0] wr_addr;
  feature_word_u             wr_word;
  // Port B, read side
  logic                      mem_rd_en;
  logic [`LAYER6_ADDR_W-1:0] mem_rd_addr;
  feature_word_u             rd_word;

  layer6_writer u_writer (
    .ck          (ck),
    .reset       (reset),
    .layer_start (layer_start),
    .act_valid   (act_valid),
    .act_data    (act_data),
    .wr_en       (wr_en),
    .wr_addr     (wr_addr),
    .wr_word     (wr_word),
    .layer_done  (layer_done)
  );

  layer6_reader u_reader (
    .ck          (ck),
    .reset       (reset),
    .rd_req      (rd_req),
    .rd_addr     (rd_addr),
    .rd_lane     (rd_lane),
    .mem_rd_en   (mem_rd_en),
    .mem_rd_addr (mem_rd_addr),
    .rd_word     (rd_word),
    .rd_valid    (rd_valid),
    .rd_data     (rd_data)
  );

  layer6_wrapper u_wrapper (
    .ck      (ck),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_word (wr_word),
    .rd_en   (mem_rd_en),
    .rd_addr (mem_rd_addr),
    .rd_word (rd_word)
  );

endmodule

// File: verification/tb_layer6_buffer.sv
`timescale 1ns/10ps
`include "layer6_consts.svh"

module tb_layer6_buffer
  import layer6_pkg::*;
();

  logic                      ck;
  logic                      reset;
  logic                      act_valid;
  logic [`ACT_W-1:0]         act_data;
  logic                      layer_start;
  logic                      rd_req;
  logic [`LAYER6_ADDR_W-1:0] rd_addr;
  lane_idx_t                 rd_lane;
  logic                      rd_valid;
  logic [`ACT_W-1:0]         rd_data;
  logic                      layer_done;

  // Reference model of the buffer and its expected outputs
  logic [`LAYER6_WORD_W-1:0] model_mem [`LAYER6_DEPTH];
  logic [`ACT_W-1:0]         model_stage [`ACT_LANES];
  int                        model_lane;
  logic [`LAYER6_ADDR_W-1:0] model_addr;
  logic                      exp_valid;
  logic                      exp_done;
  logic [`ACT_W-1:0]         exp_data;

  logic [31:0] lfsr_state;
  int          errors;
  int          checks;
  int          tests;
  int          done_pulses;
  int          collisions;

  layer6_buffer_top u_dut (
    .ck          (ck),
    .reset       (reset),
    .act_valid   (act_valid),
    .act_data    (act_data),
    .layer_start (layer_start),
    .rd_req      (rd_req),
    .rd_addr     (rd_addr),
    .rd_lane     (rd_lane),
    .rd_valid    (rd_valid),
    .rd_data     (rd_data),
    .layer_done  (layer_done)
  );

  initial begin
    ck = 1'b0;
    forever begin
      #50 ck = ~ck;
    end
  end

  //==========================================================================
  // Random bits and checking
  //==========================================================================

  // Galois form with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 32'h8020_0003;
    end
    return state >> 1;
  endfunction

  function automatic logic [31:0] random_bits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      value      = {value[30:0], lfsr_state[0]};
    end
    return value;
  endfunction

  task automatic compare(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("MISMATCH at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
    end
  endtask

  task automatic finish_test(input string name, input int start_errors);
    tests++;
    $display("%s: %0d errors", name, errors - start_errors);
  endtask

  //==========================================================================
  // Model update on each rising edge
  //==========================================================================

  task automatic model_edge();
    logic [`LAYER6_WORD_W-1:0] word;
    logic [`LAYER6_ADDR_W-1:0] target;
    if (reset) begin
      exp_valid  = 1'b0;
      exp_done   = 1'b0;
      model_lane = 0;
      model_addr = '0;
    end else begin
      // Read sees the contents from before this edge
      exp_valid = rd_req;
      exp_done  = 1'b0;
      if (rd_req) begin
        exp_data = model_mem[rd_addr][rd_lane*`ACT_W +: `ACT_W];
      end
      if (layer_start) begin
        model_lane = 0;
        model_addr = '0;
      end else if (act_valid) begin
        model_stage[model_lane] = act_data;
        if (model_lane == `ACT_LANES - 1) begin
          for (int i = 0; i < `ACT_LANES; i++) begin
            word[i*`ACT_W +: `ACT_W] = model_stage[i];
          end
          // Port B owns the word so the write goes to the neighbour
          target = model_addr;
          if (rd_req && (rd_addr == model_addr)) begin
            target[0] = ~target[0];
            collisions++;
          end
          model_mem[target] = word;
          exp_done   = (model_addr == `LAYER6_ADDR_W'(`LAYER6_DEPTH - 1));
          model_addr = model_addr + 1'b1;
          model_lane = 0;
        end else begin
          model_lane++;
        end
      end
    end
  endtask

  // Inputs in place since 1 ns after the last edge
  task automatic run_cycle();
    @(posedge ck);
    model_edge();
    #1;
    compare("rd_valid", 32'(exp_valid), 32'(rd_valid));
    compare("layer_done", 32'(exp_done), 32'(layer_done));
    if (exp_valid) begin
      compare("rd_data", 32'(exp_data), 32'(rd_data));
    end
    if (layer_done === 1'b1) begin
      done_pulses++;
    end
  endtask

  task automatic drive(input logic av, input logic [`ACT_W-1:0] ad, input logic ls,
                       input logic rq, input logic [`LAYER6_ADDR_W-1:0] ra,
                       input lane_idx_t rl);
    act_valid   = av;
    act_data    = ad;
    layer_start = ls;
    rd_req      = rq;
    rd_addr     = ra;
    rd_lane     = rl;
    run_cycle();
  endtask

  task automatic idle_cycle();
    drive(1'b0, '0, 1'b0, 1'b0, '0, '0);
  endtask

  task automatic push_act();
    drive(1'b1, `ACT_W'(random_bits(`ACT_W)), 1'b0, 1'b0, '0, '0);
  endtask

  task automatic read_word(input logic [`LAYER6_ADDR_W-1:0] addr);
    for (int l = 0; l < `ACT_LANES; l++) begin
      drive(1'b0, '0, 1'b0, 1'b1, addr, lane_idx_t'(l));
    end
    idle_cycle();
  endtask

  task automatic wait_for_done(input int limit, output int waited);
    waited = 0;
    while (layer_done !== 1'b1 && waited < limit) begin
      idle_cycle();
      waited++;
    end
    if (layer_done !== 1'b1) begin
      errors++;
      $display("Timeout at %0t: layer_done did not rise within %0d cycles", $time, limit);
    end
  endtask

  //==========================================================================
  // Test sequence
  //==========================================================================

  initial begin : main_sequence
    int                        waited;
    int                        start_errors;
    logic                      av;
    logic                      rq;
    logic                      force_hit;
    logic [`ACT_W-1:0]         ad;
    logic [`LAYER6_ADDR_W-1:0] ra;
    lane_idx_t                 rl;
    logic [`LAYER6_WORD_W-1:0] saved_word;

    lfsr_state  = 32'hd4d2;
    errors      = 0;
    checks      = 0;
    tests       = 0;
    done_pulses = 0;
    collisions  = 0;
    exp_valid   = 1'b0;
    exp_done    = 1'b0;
    exp_data    = '0;
    model_lane  = 0;
    model_addr  = '0;
    reset       = 1'b1;
    act_valid   = 1'b0;
    act_data    = '0;
    layer_start = 1'b0;
    rd_req      = 1'b0;
    rd_addr     = '0;
    rd_lane     = '0;

    start_errors = errors;
    // Live requests and bytes while reset holds the outputs low
    repeat (10) drive(1'b1, '0, 1'b0, 1'b1, '0, '0);
    reset = 1'b0;
    idle_cycle();
    finish_test("reset", start_errors);

    start_errors = errors;
    done_pulses  = 0;
    for (int i = 0; i < `LAYER6_DEPTH * `ACT_LANES; i++) begin
      push_act();
    end
    wait_for_done(4, waited);
    idle_cycle();
    for (int w = 0; w < `LAYER6_DEPTH; w++) begin
      read_word(`LAYER6_ADDR_W'(w));
    end
    finish_test("fill and read-back", start_errors);

    start_errors = errors;
    compare("layer_done pulse count", 32'd1, 32'(done_pulses));
    compare("layer_done latency", 32'd0, 32'(waited));
    // Next word wraps to address 0
    repeat (`ACT_LANES) push_act();
    idle_cycle();
    read_word('0);
    compare("layer_done pulse count", 32'd1, 32'(done_pulses));
    finish_test("completion and wrap", start_errors);

    start_errors = errors;
    for (int i = 0; i < 800; i++) begin
      av        = 1'(random_bits(1));
      ad        = `ACT_W'(random_bits(`ACT_W));
      rq        = 1'(random_bits(1));
      ra        = `LAYER6_ADDR_W'(random_bits(`LAYER6_ADDR_W));
      rl        = lane_idx_t'(random_bits(4));
      force_hit = 1'(random_bits(1));
      // Aim the read at the word being written
      if (av && force_hit && (model_lane == `ACT_LANES - 1)) begin
        rq = 1'b1;
        ra = model_addr;
      end
      drive(av, ad, 1'b0, rq, ra, rl);
    end
    idle_cycle();
    for (int w = 0; w < `LAYER6_DEPTH; w++) begin
      read_word(`LAYER6_ADDR_W'(w));
    end
    compare("collisions seen", 32'd1, 32'(collisions != 0));
    finish_test("random interleave", start_errors);

    start_errors = errors;
    drive(1'b0, '0, 1'b1, 1'b0, '0, '0);
    repeat (5) push_act();
    saved_word = model_mem[1];
    // Restart with a byte presented in the same cycle
    drive(1'b1, `ACT_W'(random_bits(`ACT_W)), 1'b1, 1'b0, '0, '0);
    repeat (`ACT_LANES) push_act();
    idle_cycle();
    read_word('0);
    for (int l = 0; l < `ACT_LANES; l++) begin
      drive(1'b0, '0, 1'b0, 1'b1, `LAYER6_ADDR_W'(1), lane_idx_t'(l));
      compare("rd_data word 1", 32'(saved_word[l*`ACT_W +: `ACT_W]), 32'(rd_data));
    end
    idle_cycle();
    finish_test("layer restart", start_errors);

    $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// File: filelist.f
+incdir+include
verilog/layer6_pkg.sv
verilog/layer6_sram.sv
verilog/layer6_wrapper.sv
verilog/layer6_writer.sv
verilog/layer6_reader.sv
verilog/layer6_buffer_top.sv
verification/tb_layer6_buffer.sv

// File: Makefile
# Verilator build and run for the layer-6 activation buffer

VERILATOR  ?= verilator
TOP        ?= tb_layer6_buffer
RTL_TOP    ?= layer6_buffer_top
FILELIST   ?= filelist.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= Test OK
VFLAGS     ?= --binary --timing
LINT_FLAGS ?= --lint-only --timing -Wall

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard include/*.svh)
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM)

$(SIM): $(FILELIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(SIM) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
